//--- compile.f
+incdir+include
design/knight_pkg.sv
design/move_sequencer.sv
design/frwrd_ramp.sv
design/square_counter.sv
design/heading_error.sv
design/knight_cmd_proc.sv
sim/knight_cmd_proc_checker.sv
sim/knight_cmd_proc_tb.sv

//--- design/frwrd_ramp.sv
`timescale 1ns/1ps
`default_nettype none

`include "knight_config.svh"

module frwrd_ramp (
  input  logic                    clk,         // System clock.
  input  logic                    rst_n,       // Async active-low reset.
  input  knight_pkg::motion_ctl_t ctl,         // Sequencer controls.
  input  logic                    heading_rdy, // Gyro strobe paces the ramp.
  output logic [`KNIGHT_SPD_W-1:0] frwrd,      // Forward speed to the motors.
  output logic                    spd_zero     // Speed is at rest.
);

  localparam int SW = `KNIGHT_SPD_W;
  localparam logic [SW-1:0] INC_AMT = SW'(`KNIGHT_INC_AMT);  // Up step.
  localparam logic [SW-1:0] DEC_AMT = SW'(`KNIGHT_DEC_AMT);  // Down step.

  logic max_spd;                               // Top two bits set means capped.

  assign max_spd  = &frwrd[SW-1:SW-2];
  assign spd_zero = (frwrd == '0);

  ////////////////////
  // Speed register
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      frwrd <= '0;
    end else if (ctl.clr_frwrd) begin
      frwrd <= '0;                             // Fresh start for a move.
    end else if (heading_rdy) begin            // One step per gyro sample.
      if (ctl.inc_frwrd) begin
        if (!max_spd) begin
          frwrd <= frwrd + INC_AMT;
        end
      end else if (ctl.dec_frwrd) begin
        // Clamp at zero instead of wrapping.
        frwrd <= (frwrd > DEC_AMT) ? frwrd - DEC_AMT : '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/heading_error.sv
`timescale 1ns/1ps
`default_nettype none

`include "knight_config.svh"

module heading_error (
  input  logic                             clk,          // System clock.
  input  logic                             rst_n,        // Async active-low reset.
  input  logic                             move_cmd,     // Load desired heading.
  input  logic [7:0]                       cmd_heading,  // Coarse heading field.
  input  logic signed [`KNIGHT_HEAD_W-1:0] heading,      // Gyro heading.
  input  logic                             lft_ir,       // Drifted onto left line.
  input  logic                             rght_ir,      // Drifted onto right line.
  output logic signed [`KNIGHT_HEAD_W-1:0] error,        // Error term to the PID.
  output logic                             aligned       // Close enough to drive.
);

  localparam int HW = `KNIGHT_HEAD_W;
  localparam logic signed [HW-1:0] NUDGE_POS = HW'(`KNIGHT_NUDGE_POS);
  localparam logic signed [HW-1:0] NUDGE_NEG = HW'(`KNIGHT_NUDGE_NEG);
  localparam logic [HW-1:0] THRESH = HW'(`KNIGHT_ALIGN_THRESH);

  logic signed [HW-1:0] desired_heading;       // Target from the command.
  logic signed [HW-1:0] err_nudge;             // IR steering bias.
  logic [HW-1:0]        error_abs;             // Magnitude of error.

  ////////////////////
  // Desired heading
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      desired_heading <= '0;
    end else if (move_cmd) begin
      if (cmd_heading == 8'h00) begin
        desired_heading <= '0;                 // North stays exactly zero.
      end else begin
        desired_heading <= {cmd_heading, 4'hF}; // Fill the low nibble.
      end
    end
  end

  ////////////////////
  // Error term
  ////////////////////
  // Left IR wins if both are set.
  always_comb begin
    if (lft_ir) begin
      err_nudge = NUDGE_POS;
    end else if (rght_ir) begin
      err_nudge = NUDGE_NEG;
    end else begin
      err_nudge = '0;
    end
  end

  assign error     = heading - desired_heading + err_nudge;  // Wraps like the gyro.
  assign error_abs = error[HW-1] ? -error : error;
  assign aligned   = (error_abs < THRESH);

endmodule

`default_nettype wire

//--- design/knight_cmd_proc.sv
`timescale 1ns/1ps
`default_nettype none

`include "knight_config.svh"

module knight_cmd_proc (
  input  logic                             clk,          // System clock.
  input  logic                             rst_n,        // Async active-low reset.
  input  knight_pkg::cmd_t                 cmd,          // Command from the host.
  input  logic                             cmd_rdy,      // Command valid.
  input  logic                             cal_done,     // Gyro calibration finished.
  input  logic signed [`KNIGHT_HEAD_W-1:0] heading,      // Gyro heading.
  input  logic                             heading_rdy,  // New gyro sample.
  input  logic                             lft_ir,       // Left line sensor.
  input  logic                             cntr_ir,      // Center line sensor.
  input  logic                             rght_ir,      // Right line sensor.
  output logic                             clr_cmd_rdy,  // Command consumed.
  output logic                             send_resp,    // Command finished.
  output logic                             strt_cal,     // Start calibration.
  output logic                             moving,       // Robot in motion.
  output logic                             tour_go,      // Start the tour.
  output logic                             fanfare_go,   // Play the fanfare.
  output logic signed [`KNIGHT_HEAD_W-1:0] error,        // Heading error to PID.
  output logic [`KNIGHT_SPD_W-1:0]         frwrd         // Forward speed.
);

  knight_pkg::motion_ctl_t ctl;                // Sequencer to datapath.
  logic                    spd_zero;           // Speed at rest.
  logic                    move_done;          // Line count reached.
  logic                    aligned;            // Heading close enough.

  move_sequencer seq_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_rdy     (cmd_rdy),
    .opcode      (cmd.opcode),
    .cal_done    (cal_done),
    .aligned     (aligned),
    .move_done   (move_done),
    .spd_zero    (spd_zero),
    .ctl         (ctl),
    .clr_cmd_rdy (clr_cmd_rdy),
    .strt_cal    (strt_cal),
    .send_resp   (send_resp),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go),
    .moving      (moving)
  );

  frwrd_ramp ramp_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctl         (ctl),
    .heading_rdy (heading_rdy),
    .frwrd       (frwrd),
    .spd_zero    (spd_zero)
  );

  square_counter sq_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .move_cmd  (ctl.move_cmd),
    .squares   (cmd.squares),
    .cntr_ir   (cntr_ir),
    .move_done (move_done)
  );

  heading_error herr_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .move_cmd    (ctl.move_cmd),
    .cmd_heading (cmd.heading),
    .heading     (heading),
    .lft_ir      (lft_ir),
    .rght_ir     (rght_ir),
    .error       (error),
    .aligned     (aligned)
  );

endmodule

`default_nettype wire

//--- design/knight_pkg.sv
`default_nettype none

package knight_pkg;

  ////////////////////
  // Command opcodes
  ////////////////////
  typedef enum logic [3:0] {
    CAL     = 4'b0010,              // Gyro calibration.
    MOV     = 4'b0100,              // Plain move of N squares.
    FANFARE = 4'b0101,              // Move with the charge tune.
    TOUR    = 4'b0110               // Hand off to the tour logic.
  } op_t;

  // Host command word, opcode in the top nibble.
  typedef struct packed {
    op_t        opcode;             // Function to perform.
    logic [7:0] heading;            // Coarse desired heading.
    logic [3:0] squares;            // Squares to travel.
  } cmd_t;

  ////////////////////
  // Sequencer states
  ////////////////////
  typedef enum logic [2:0] {
    IDLE,                           // Waiting on cmd_rdy.
    CALIBRATE,                      // Waiting on cal_done.
    MOVE,                           // Turning toward the heading.
    INCR,                           // Ramping up and counting lines.
    DECR                            // Ramping down to a stop.
  } state_t;

  // Controls from the sequencer to the datapath blocks.
  typedef struct packed {
    logic clr_frwrd;                // Zero the speed register.
    logic inc_frwrd;                // Ramp up on gyro strobes.
    logic dec_frwrd;                // Ramp down on gyro strobes.
    logic move_cmd;                 // Load heading and squares from cmd.
  } motion_ctl_t;

endpackage

`default_nettype wire

//--- design/move_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module move_sequencer (
  input  logic                   clk,          // System clock.
  input  logic                   rst_n,        // Async active-low reset.
  input  logic                   cmd_rdy,      // Host has a command waiting.
  input  knight_pkg::op_t        opcode,       // Opcode of the waiting command.
  input  logic                   cal_done,     // Gyro calibration finished.
  input  logic                   aligned,      // Heading error inside threshold.
  input  logic                   move_done,    // All line crossings seen.
  input  logic                   spd_zero,     // Forward speed is zero.
  output knight_pkg::motion_ctl_t ctl,         // Datapath controls.
  output logic                   clr_cmd_rdy,  // Command consumed.
  output logic                   strt_cal,     // Kick off gyro calibration.
  output logic                   send_resp,    // Command finished.
  output logic                   tour_go,      // Start the tour.
  output logic                   fanfare_go,   // Play the fanfare.
  output logic                   moving        // Robot in motion.
);

  knight_pkg::state_t state;                   // Current state.
  knight_pkg::state_t nxt_state;               // Next state.
  knight_pkg::op_t    op_lat;                  // Opcode held for the whole command.
  logic               accept;                  // Command taken this cycle.

  assign accept = (state == knight_pkg::IDLE) && cmd_rdy;

  ////////////////////
  // State and opcode
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state <= knight_pkg::IDLE;               // Come up idle.
    end else begin
      state <= nxt_state;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      op_lat <= knight_pkg::MOV;
    end else if (accept) begin
      op_lat <= opcode;                        // Host may drop cmd after clr_cmd_rdy.
    end
  end

  ////////////////////
  // Transitions
  ////////////////////
  always_comb begin
    nxt_state     = state;                     // Hold by default.
    ctl           = '0;                        // No datapath action.
    clr_cmd_rdy   = 1'b0;
    strt_cal      = 1'b0;
    send_resp     = 1'b0;
    tour_go       = 1'b0;
    fanfare_go    = 1'b0;
    moving        = 1'b0;

    case (state)
      knight_pkg::CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;                    // Report calibration done.
          nxt_state = knight_pkg::IDLE;
        end
      end

      knight_pkg::MOVE: begin
        moving = 1'b1;                         // Turning in place counts as moving.
        if (aligned) begin
          ctl.clr_frwrd = 1'b1;                // Start the ramp from rest.
          nxt_state     = knight_pkg::INCR;
        end
      end

      knight_pkg::INCR: begin
        moving        = 1'b1;
        ctl.inc_frwrd = 1'b1;                  // Ramp up toward the cap.
        if (move_done) begin
          fanfare_go = (op_lat == knight_pkg::FANFARE);  // Tune starts as we brake.
          nxt_state  = knight_pkg::DECR;
        end
      end

      knight_pkg::DECR: begin
        ctl.dec_frwrd = 1'b1;                  // Ramp down.
        if (spd_zero) begin
          send_resp = 1'b1;                    // Stopped, so report.
          nxt_state = knight_pkg::IDLE;
        end else begin
          moving = 1'b1;                       // Still rolling.
        end
      end

      default: begin                           // IDLE.
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;                  // Consume whatever is offered.
          case (opcode)
            knight_pkg::CAL: begin
              strt_cal  = 1'b1;
              nxt_state = knight_pkg::CALIBRATE;
            end
            knight_pkg::TOUR: begin
              tour_go = 1'b1;                  // Tour logic takes over, stay idle.
            end
            knight_pkg::MOV, knight_pkg::FANFARE: begin
              ctl.move_cmd = 1'b1;             // Load heading and squares.
              nxt_state    = knight_pkg::MOVE;
            end
            default: begin
              nxt_state = knight_pkg::IDLE;    // Unknown opcode is dropped.
            end
          endcase
        end
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/square_counter.sv
`timescale 1ns/1ps
`default_nettype none

module square_counter (
  input  logic       clk,                      // System clock.
  input  logic       rst_n,                    // Async active-low reset.
  input  logic       move_cmd,                 // New move, load and clear.
  input  logic [3:0] squares,                  // Squares requested.
  input  logic       cntr_ir,                  // Center IR over a line.
  output logic       move_done                 // Enough lines crossed.
);

  logic       cntr_prev;                       // Last cntr_ir sample.
  logic       cntr_rise;                       // Start of a line.
  logic [3:0] sq_cnt;                          // Held square count.
  logic [4:0] edge_cnt;                        // Lines crossed so far.

  ////////////////////
  // Edge detect
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cntr_prev <= 1'b0;
    end else begin
      cntr_prev <= cntr_ir;
    end
  end

  assign cntr_rise = cntr_ir & ~cntr_prev;

  ////////////////////
  // Counters
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      sq_cnt <= 4'h0;
    end else if (move_cmd) begin
      sq_cnt <= squares;                       // Taken from the accepted command.
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      edge_cnt <= 5'h00;
    end else if (move_cmd) begin
      edge_cnt <= 5'h00;
    end else if (cntr_rise && (edge_cnt != 5'h1F)) begin
      edge_cnt <= edge_cnt + 5'h01;            // Holds at 31.
    end
  end

  // Two lines per square.
  assign move_done = (edge_cnt == {sq_cnt, 1'b0});

endmodule

`default_nettype wire

//--- include/knight_config.svh
`ifndef KNIGHT_CONFIG_SVH
`define KNIGHT_CONFIG_SVH

////////////////////
// Build switch
////////////////////
// Nonzero picks the short ramp and nudge values used in simulation.
`define KNIGHT_FAST_SIM 1

////////////////////
// Field widths
////////////////////
`define KNIGHT_HEAD_W 12            // Gyro heading and error width.
`define KNIGHT_SPD_W 10             // Forward speed width.

////////////////////
// Speed ramp
////////////////////
// Step added to frwrd on each gyro strobe while ramping up.
`define KNIGHT_INC_AMT ((`KNIGHT_FAST_SIM != 0) ? 'h020 : 'h003)
// Step taken off frwrd on each gyro strobe while ramping down.
`define KNIGHT_DEC_AMT ((`KNIGHT_FAST_SIM != 0) ? 'h040 : 'h006)

////////////////////
// Heading control
////////////////////
// Nudge toward the right when the left IR sees the line.
`define KNIGHT_NUDGE_POS ((`KNIGHT_FAST_SIM != 0) ? 'h1FF : 'h05F)
// Nudge toward the left when the right IR sees the line, as a 12-bit pattern.
`define KNIGHT_NUDGE_NEG ((`KNIGHT_FAST_SIM != 0) ? 'hE00 : 'hFA1)
`define KNIGHT_ALIGN_THRESH 'h02C   // Abs error below this counts as aligned.

`endif

//--- run_sim.sh
#!/bin/sh
# Build the knight command processor testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
  --top-module knight_cmd_proc_tb -o knight_sim || { echo "Build failed"; exit 1; }

# Keep running past assertion errors so the testbench can report them.
out=$(./obj_dir/knight_sim +verilator+error+limit+1000 2>&1)
echo "$out"

echo "$out" | grep -q "^TB PASSED$" && echo "Simulation passed" || {
  echo "Simulation failed"
  exit 1
}

//--- sim/knight_cmd_proc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module knight_cmd_proc_checker (
  input logic               clk,               // System clock.
  input logic               rst_n,             // Async active-low reset.
  input knight_pkg::state_t state,             // Sequencer state.
  input logic               cmd_rdy,           // Host command valid.
  input logic               clr_cmd_rdy,       // Command consumed.
  input logic               strt_cal,          // Calibration start strobe.
  input logic               tour_go,           // Tour start strobe.
  input logic               send_resp,         // Response strobe.
  input logic               moving             // Robot in motion.
);

  int fail_cnt = 0;                            // Read back by the testbench.

  ////////////////////
  // Strobes
  ////////////////////
  a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({strt_cal, tour_go, send_resp}))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("strt_cal, tour_go and send_resp overlap");
    end

  // Consume only what the host offers.
  a_clr_needs_rdy: assert property (@(posedge clk) disable iff (!rst_n)
      clr_cmd_rdy |-> cmd_rdy)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("clr_cmd_rdy high without cmd_rdy");
    end

  ////////////////////
  // Motion
  ////////////////////
  a_idle_still: assert property (@(posedge clk) disable iff (!rst_n)
      (state == knight_pkg::IDLE) |-> !moving)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("moving high while idle");
    end

endmodule

bind move_sequencer knight_cmd_proc_checker chk_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .state       (state),
  .cmd_rdy     (cmd_rdy),
  .clr_cmd_rdy (clr_cmd_rdy),
  .strt_cal    (strt_cal),
  .tour_go     (tour_go),
  .send_resp   (send_resp),
  .moving      (moving)
);

`default_nettype wire

//--- sim/knight_cmd_proc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "knight_config.svh"

module knight_cmd_proc_tb;

  localparam int NUM_ENTRIES = 8;
  localparam int CYCLE_LIMIT = 400 * NUM_ENTRIES;  // Budget per table entry.
  localparam int RAND_TRIES  = 4;                  // LFSR IR patterns per move.
  localparam int CAL_WAIT    = 3;                  // Idle cycles before cal_done.
  localparam int HW          = `KNIGHT_HEAD_W;
  localparam int SW          = `KNIGHT_SPD_W;
  localparam logic [SW-1:0] INC_AMT   = SW'(`KNIGHT_INC_AMT);
  localparam logic [SW-1:0] DEC_AMT   = SW'(`KNIGHT_DEC_AMT);
  localparam logic [SW-1:0] SPD_CAP   = {2'b11, {(SW-2){1'b0}}};  // Top two bits set.
  localparam logic [HW-1:0] NUDGE_POS = HW'(`KNIGHT_NUDGE_POS);
  localparam logic [HW-1:0] NUDGE_NEG = HW'(`KNIGHT_NUDGE_NEG);
  localparam logic [HW-1:0] THRESH    = HW'(`KNIGHT_ALIGN_THRESH);

  // One row of the stimulus table.
  typedef struct packed {
    knight_pkg::op_t op;                           // Command opcode.
    logic [7:0]      hdg_fld;                      // Coarse heading field.
    logic [3:0]      squares;                      // Squares to travel.
    logic [HW-1:0]   gyro;                         // Gyro heading in first MOVE cycle.
    logic            lft;                          // Left IR in first MOVE cycle.
    logic            rght;                         // Right IR in first MOVE cycle.
    logic [HW-1:0]   exp_err;                      // Error expected in that cycle.
  } entry_t;

  logic                 clk = 1'b0;
  logic                 rst_n;
  knight_pkg::cmd_t     cmd;
  logic                 cmd_rdy;
  logic                 cal_done;
  logic signed [HW-1:0] heading;
  logic                 heading_rdy;
  logic                 lft_ir;
  logic                 cntr_ir;
  logic                 rght_ir;
  logic                 clr_cmd_rdy;
  logic                 send_resp;
  logic                 strt_cal;
  logic                 moving;
  logic                 tour_go;
  logic                 fanfare_go;
  logic signed [HW-1:0] error;
  logic [SW-1:0]        frwrd;

  entry_t      tbl [NUM_ENTRIES];                  // Stimulus table.
  int          errors = 0;                         // Failed checks.
  int          sva_fails;                          // Checker assertion failures.
  int          cycles = 0;                         // Watchdog count.
  logic [15:0] lfsr = 16'd97;                      // LFSR state, seeded.

  knight_cmd_proc dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_rdy     (cmd_rdy),
    .cal_done    (cal_done),
    .heading     (heading),
    .heading_rdy (heading_rdy),
    .lft_ir      (lft_ir),
    .cntr_ir     (cntr_ir),
    .rght_ir     (rght_ir),
    .clr_cmd_rdy (clr_cmd_rdy),
    .send_resp   (send_resp),
    .strt_cal    (strt_cal),
    .moving      (moving),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go),
    .error       (error),
    .frwrd       (frwrd)
  );

  always #2 clk = ~clk;                            // 4 ns period.

  ////////////////////
  // Watchdog
  ////////////////////
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the DUT never finished a command", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////
  // Reference model
  ////////////////////
  // x^16 + x^14 + x^13 + x^11 + 1, new bit enters at bit 0.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [HW-1:0] desired_of(input logic [7:0] fld);
    return (fld == 8'h00) ? '0 : HW'(int'(fld) * 16 + 15);  // Field then four ones.
  endfunction

  function automatic logic [HW-1:0] expect_error(input logic [7:0] fld,
      input logic [HW-1:0] gyro, input logic lft, input logic rght);
    logic [HW-1:0] nudge;
    nudge = lft ? NUDGE_POS : (rght ? NUDGE_NEG : '0);  // Left has priority.
    return gyro - desired_of(fld) + nudge;
  endfunction

  function automatic logic is_aligned(input logic [HW-1:0] e);
    logic [HW-1:0] mag;
    mag = e[HW-1] ? (~e + HW'(1)) : e;             // Two's complement magnitude.
    return mag < THRESH;
  endfunction

  ////////////////////
  // Helpers
  ////////////////////
  task automatic take_bits(input int n, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);                      // One step per bit.
      bits = {bits[14:0], lfsr[0]};
    end
  endtask

  task automatic compare_bit(input string name, input logic exp_v, input logic act_v);
    assert (act_v === exp_v) else begin
      errors++;
      $display("** Error at %0t: %s expected %0b, got %0b", $time, name, exp_v, act_v);
    end
  endtask

  task automatic compare_word(input string name, input logic [HW-1:0] exp_v,
      input logic [HW-1:0] act_v);
    assert (act_v === exp_v) else begin
      errors++;
      $display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_strobes(input logic e_clr, input logic e_cal, input logic e_resp,
      input logic e_tour, input logic e_fan, input logic e_mov);
    compare_bit("clr_cmd_rdy", e_clr, clr_cmd_rdy);
    compare_bit("strt_cal", e_cal, strt_cal);
    compare_bit("send_resp", e_resp, send_resp);
    compare_bit("tour_go", e_tour, tour_go);
    compare_bit("fanfare_go", e_fan, fanfare_go);
    compare_bit("moving", e_mov, moving);
  endtask

  task automatic begin_cycle();
    @(negedge clk);                                // Inputs change on the falling edge.
    cmd_rdy     = 1'b0;
    cal_done    = 1'b0;
    heading_rdy = 1'b0;
    cntr_ir     = 1'b0;
    lft_ir      = 1'b0;
    rght_ir     = 1'b0;
  endtask

  task automatic offer_cmd(input entry_t e);
    begin_cycle();
    cmd.opcode  = e.op;
    cmd.heading = e.hdg_fld;
    cmd.squares = e.squares;
    cmd_rdy     = 1'b1;
    #1;                                            // Let the accept logic settle.
  endtask

  ////////////////////
  // Command flows
  ////////////////////
  task automatic cal_sequence(input entry_t e);
    offer_cmd(e);
    check_strobes(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    for (int i = 0; i < CAL_WAIT; i++) begin
      begin_cycle();
      #1;
      check_strobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);  // Still calibrating.
    end
    begin_cycle();
    cal_done = 1'b1;
    #1;
    check_strobes(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    begin_cycle();
    #1;
    check_strobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);    // Only one response.
  endtask

  task automatic tour_sequence(input entry_t e);
    offer_cmd(e);
    check_strobes(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);    // Next entry follows at once.
  endtask

  task automatic move_sequence(input entry_t e);
    logic [HW-1:0] want;
    logic [HW-1:0] exp_err;
    logic [15:0]   bits;
    logic [SW-1:0] exp_frwrd;
    logic          aligned_seen;
    logic          braking;
    logic          exp_stop;
    logic          exp_fan;
    logic          finished;
    logic          prev_ir;
    logic          pulsing;
    int            sq;
    int            beat;
    int            edges;
    int            pulses_left;
    int            pulse_ph;
    int            fan_cnt;
    int            spd;

    want = desired_of(e.hdg_fld);
    sq   = int'(e.squares);
    offer_cmd(e);
    check_strobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);

    // First turning cycle uses the table values.
    begin_cycle();
    heading = e.gyro;
    lft_ir  = e.lft;
    rght_ir = e.rght;
    #1;
    compare_word("error", e.exp_err, error);
    check_strobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    aligned_seen = is_aligned(e.exp_err);

    for (int i = 0; i < RAND_TRIES; i++) begin
      if (!aligned_seen) begin                     // Stop once the turn is done.
        begin_cycle();
        take_bits(HW, bits);
        heading = bits[HW-1:0];
        take_bits(1, bits);
        lft_ir = bits[0];
        take_bits(1, bits);
        rght_ir = bits[0];
        exp_err = expect_error(e.hdg_fld, heading, lft_ir, rght_ir);
        #1;
        compare_word("error", exp_err, error);
        compare_bit("moving", 1'b1, moving);
        aligned_seen = is_aligned(exp_err);
      end
    end

    if (!aligned_seen) begin
      begin_cycle();
      heading = want;                              // Zero error ends the turn.
      #1;
      compare_word("error", expect_error(e.hdg_fld, want, 1'b0, 1'b0), error);
      compare_bit("moving", 1'b1, moving);
    end

    ////////////////////
    // Ramp and count
    ////////////////////
    exp_frwrd   = '0;
    braking     = 1'b0;
    finished    = 1'b0;
    prev_ir     = 1'b0;
    pulsing     = 1'b0;
    beat        = 0;
    edges       = 0;
    pulses_left = 2 * sq;                          // Two lines per square.
    pulse_ph    = 0;
    fan_cnt     = 0;
    while (!finished) begin
      begin_cycle();
      heading     = want;
      heading_rdy = (beat % 4 == 0);               // Gyro strobe every fourth cycle.
      beat++;
      if (!pulsing && (pulses_left > 0) && (frwrd == SPD_CAP)) begin
        pulsing = 1'b1;                            // Cruising, start crossing lines.
      end
      cntr_ir = pulsing && (pulse_ph < 2);
      if (pulsing) begin
        pulse_ph++;
        if (pulse_ph == 4) begin
          pulse_ph    = 0;
          pulses_left--;
          pulsing     = (pulses_left > 0);
        end
      end
      #1;
      exp_stop = braking && (exp_frwrd == '0);
      exp_fan  = !braking && (edges == 2 * sq) && (e.op == knight_pkg::FANFARE);
      compare_word("frwrd", HW'(exp_frwrd), HW'(frwrd));
      check_strobes(1'b0, 1'b0, exp_stop, 1'b0, exp_fan, !exp_stop);
      if (fanfare_go) begin
        fan_cnt++;
      end
      finished = send_resp;                        // Wait on the DUT's response.

      // Advance the model across the coming rising edge.
      if (!braking) begin
        if (heading_rdy && (exp_frwrd < SPD_CAP)) begin
          exp_frwrd = exp_frwrd + INC_AMT;
        end
        if (edges == 2 * sq) begin
          braking = 1'b1;
        end
      end else if (heading_rdy) begin
        spd       = int'(exp_frwrd) - int'(DEC_AMT);
        exp_frwrd = (spd < 0) ? '0 : SW'(spd);     // Floor at zero.
      end
      if (cntr_ir && !prev_ir && (edges < 31)) begin
        edges++;
      end
      prev_ir = cntr_ir;
    end
    compare_word("fanfare_go pulses", (e.op == knight_pkg::FANFARE) ? 12'd1 : 12'd0,
                 12'(fan_cnt));
  endtask

  task automatic fill_table();
    tbl[0] = '{knight_pkg::CAL,     8'h00, 4'h0, 12'h000, 1'b0, 1'b0, 12'h000};
    tbl[1] = '{knight_pkg::TOUR,    8'h00, 4'h0, 12'h000, 1'b0, 1'b0, 12'h000};
    tbl[2] = '{knight_pkg::MOV,     8'h00, 4'h1, 12'h050, 1'b0, 1'b0, 12'h050};
    tbl[3] = '{knight_pkg::TOUR,    8'h00, 4'h0, 12'h000, 1'b0, 1'b0, 12'h000};
    tbl[4] = '{knight_pkg::FANFARE, 8'h80, 4'h1, 12'h000, 1'b0, 1'b1, 12'h5F1};
    tbl[5] = '{knight_pkg::MOV,     8'h3F, 4'h2, 12'h400, 1'b1, 1'b0, 12'h200};
    tbl[6] = '{knight_pkg::FANFARE, 8'h12, 4'h3, 12'h125, 1'b1, 1'b1, 12'h1F5};
    // Zero squares, brakes from a single step below DEC_AMT.
    tbl[7] = '{knight_pkg::MOV,     8'h01, 4'h0, 12'h000, 1'b0, 1'b0, 12'hFE1};
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    rst_n       = 1'b0;
    cmd.opcode  = knight_pkg::MOV;
    cmd.heading = 8'h00;
    cmd.squares = 4'h0;
    cmd_rdy     = 1'b0;
    cal_done    = 1'b0;
    heading     = '0;
    heading_rdy = 1'b0;
    lft_ir      = 1'b0;
    cntr_ir     = 1'b0;
    rght_ir     = 1'b0;
    fill_table();
    repeat (2) @(posedge clk);                     // Two cycles in reset.
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    compare_word("frwrd", '0, HW'(frwrd));
    check_strobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      case (tbl[i].op)
        knight_pkg::CAL:  cal_sequence(tbl[i]);
        knight_pkg::TOUR: tour_sequence(tbl[i]);
        default:          move_sequence(tbl[i]);
      endcase
    end

    sva_fails = dut_i.seq_i.chk_i.fail_cnt;
    $display("Checks done, %0d check errors, %0d assertion failures", errors, sva_fails);
    if ((errors == 0) && (sva_fails == 0)) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
